/* src/xcvr_rcfg_pkg.sv */
// ======================================================================
// Shared widths, soft register offsets and register bit positions
// ======================================================================
`default_nettype none

package xcvr_rcfg_pkg;

  // Bus widths
  localparam int data_width       = 32;
  localparam int chan_addr_bits   = 10;
  localparam int xcvr_data_width  = 8;
  localparam int csr_sel_bit      = 9;
  localparam int csr_offset_width = 9;
  localparam int prbs_count_width = 50;
  // Counters are read back in bytes, least significant first
  localparam int prbs_count_bytes = 7;

  // Soft register offsets
  localparam logic [csr_offset_width-1:0] reg_status        = 9'h001;
  localparam logic [csr_offset_width-1:0] reg_control       = 9'h002;
  localparam logic [csr_offset_width-1:0] reg_cal_mask      = 9'h003;
  localparam logic [csr_offset_width-1:0] reg_prbs_ctrl     = 9'h004;
  localparam logic [csr_offset_width-1:0] reg_prbs_err_base = 9'h008;
  localparam logic [csr_offset_width-1:0] reg_prbs_bit_base = 9'h010;

  // Status bits
  localparam int stat_lockedtoref  = 0;
  localparam int stat_lockedtodata = 1;
  localparam int stat_tx_cal_busy  = 2;
  localparam int stat_rx_cal_busy  = 3;
  localparam int stat_prbs_done    = 4;

  // Control override bits
  localparam int ctrl_bits          = 7;
  localparam int ctrl_set_locktoref  = 0;
  localparam int ctrl_set_locktodata = 1;
  localparam int ctrl_serial_lpbk    = 2;
  localparam int ctrl_rx_analogreset = 3;
  localparam int ctrl_rx_digitalreset = 4;
  localparam int ctrl_tx_analogreset = 5;
  localparam int ctrl_tx_digitalreset = 6;

  // Calibration mask and PRBS command bits
  localparam int mask_tx       = 0;
  localparam int mask_rx       = 1;
  localparam int prbs_en_bit   = 0;
  localparam int prbs_snap_bit = 1;
  localparam int prbs_clr_bit  = 2;

endpackage

`default_nettype wire

/* src/prbs_accum.sv */
// ======================================================================
// PRBS error and bit counters with snapshot registers
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module prbs_accum (
  input  wire                                        reconfig_clk,
  input  wire                                        rst,
  input  wire                                        prbs_count_en,
  input  wire                                        prbs_snapshot,
  input  wire                                        prbs_clear,
  input  wire                                        prbs_err_signal,
  input  wire                                        prbs_done_signal,
  output logic [xcvr_rcfg_pkg::prbs_count_width-1:0] err_snap,
  output logic [xcvr_rcfg_pkg::prbs_count_width-1:0] bit_snap
);
  import xcvr_rcfg_pkg::*;

  logic [prbs_count_width-1:0] err_cnt;
  logic [prbs_count_width-1:0] bit_cnt;

  always_ff @(posedge reconfig_clk) begin
    if (rst || prbs_clear) begin
      err_cnt  <= '0;
      bit_cnt  <= '0;
      err_snap <= '0;
      bit_snap <= '0;
    end else begin
      // Count only once the checker reports lock on the pattern
      if (prbs_count_en && prbs_done_signal) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (prbs_err_signal) begin
          err_cnt <= err_cnt + 1'b1;
        end
      end
      if (prbs_snapshot) begin
        err_snap <= err_cnt;
        bit_snap <= bit_cnt;
      end
    end
  end

  // Errors are counted only on counted bits
  a_err_le_bits: assert property (@(posedge reconfig_clk) disable iff (rst)
    (err_cnt <= bit_cnt) && (err_snap <= bit_snap));

endmodule

`default_nettype wire

/* src/chan_soft_csr.sv */
// ======================================================================
// Per-channel soft registers: status, control overrides, PRBS commands
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module chan_soft_csr (
  input  wire                                         reconfig_clk,
  input  wire                                         rst,
  input  wire                                         csr_write,
  input  wire                                         csr_read,
  input  wire  [xcvr_rcfg_pkg::csr_offset_width-1:0]  csr_offset,
  input  wire  [xcvr_rcfg_pkg::xcvr_data_width-1:0]   csr_writedata,
  output logic [xcvr_rcfg_pkg::xcvr_data_width-1:0]   csr_readdata,
  input  wire                                         in_rx_is_lockedtoref,
  input  wire                                         in_rx_is_lockedtodata,
  input  wire                                         in_tx_cal_busy,
  input  wire                                         in_rx_cal_busy,
  input  wire                                         in_rx_prbs_err_clr,
  input  wire                                         in_set_rx_locktoref,
  input  wire                                         in_set_rx_locktodata,
  input  wire                                         in_en_serial_lpbk,
  input  wire                                         in_rx_analogreset,
  input  wire                                         in_rx_digitalreset,
  input  wire                                         in_tx_analogreset,
  input  wire                                         in_tx_digitalreset,
  input  wire                                         prbs_done_signal,
  input  wire  [xcvr_rcfg_pkg::prbs_count_width-1:0]  err_snap,
  input  wire  [xcvr_rcfg_pkg::prbs_count_width-1:0]  bit_snap,
  output logic                                        prbs_count_en,
  output logic                                        prbs_snapshot,
  output logic                                        prbs_clear,
  output logic                                        out_prbs_err_clr,
  output logic                                        out_set_rx_locktoref,
  output logic                                        out_set_rx_locktodata,
  output logic                                        out_en_serial_lpbk,
  output logic                                        out_rx_analogreset,
  output logic                                        out_rx_digitalreset,
  output logic                                        out_tx_analogreset,
  output logic                                        out_tx_digitalreset,
  output logic                                        out_tx_cal_busy_mask,
  output logic                                        out_rx_cal_busy_mask
);
  import xcvr_rcfg_pkg::*;

  localparam int snap_bytes_w = prbs_count_bytes * 8;

  logic [ctrl_bits-1:0]       ctrl_reg;
  logic [1:0]                 cal_mask;
  logic                       snap_q;
  logic                       clr_q;
  logic                       prbs_wr;
  logic [xcvr_data_width-1:0] status_byte;
  logic [xcvr_data_width-1:0] rd_byte;
  logic [snap_bytes_w-1:0]    err_bytes;
  logic [snap_bytes_w-1:0]    bit_bytes;

  assign prbs_wr = csr_write && (csr_offset == reg_prbs_ctrl);

  always_ff @(posedge reconfig_clk) begin
    if (rst) begin
      ctrl_reg      <= '0;
      cal_mask      <= 2'b11;
      prbs_count_en <= 1'b0;
      snap_q        <= 1'b0;
      clr_q         <= 1'b0;
    end else begin
      // Snapshot and clear last for one cycle after the write
      snap_q <= prbs_wr && csr_writedata[prbs_snap_bit];
      clr_q  <= prbs_wr && csr_writedata[prbs_clr_bit];
      if (prbs_wr) begin
        prbs_count_en <= csr_writedata[prbs_en_bit];
      end
      if (csr_write && (csr_offset == reg_control)) begin
        ctrl_reg <= csr_writedata[ctrl_bits-1:0];
      end
      if (csr_write && (csr_offset == reg_cal_mask)) begin
        cal_mask <= csr_writedata[1:0];
      end
    end
  end

  assign err_bytes = snap_bytes_w'(err_snap);
  assign bit_bytes = snap_bytes_w'(bit_snap);

  always_comb begin
    status_byte = '0;
    status_byte[stat_lockedtoref]  = in_rx_is_lockedtoref;
    status_byte[stat_lockedtodata] = in_rx_is_lockedtodata;
    status_byte[stat_tx_cal_busy]  = in_tx_cal_busy;
    status_byte[stat_rx_cal_busy]  = in_rx_cal_busy;
    status_byte[stat_prbs_done]    = prbs_done_signal;

    // Counter bytes sit on 8-aligned bases, so the low 3 bits pick the byte
    rd_byte = '0;
    case (csr_offset)
      reg_status:    rd_byte = status_byte;
      reg_control:   rd_byte = xcvr_data_width'(ctrl_reg);
      reg_cal_mask:  rd_byte = xcvr_data_width'(cal_mask);
      reg_prbs_ctrl: rd_byte = xcvr_data_width'({clr_q, snap_q, prbs_count_en});
      default: begin
        if (csr_offset >= reg_prbs_err_base &&
            csr_offset < reg_prbs_err_base + prbs_count_bytes) begin
          rd_byte = err_bytes[csr_offset[2:0]*8 +: 8];
        end else if (csr_offset >= reg_prbs_bit_base &&
                     csr_offset < reg_prbs_bit_base + prbs_count_bytes) begin
          rd_byte = bit_bytes[csr_offset[2:0]*8 +: 8];
        end
      end
    endcase
  end

  always_ff @(posedge reconfig_clk) begin
    if (csr_read) begin
      csr_readdata <= rd_byte;
    end
  end

  assign prbs_snapshot    = snap_q;
  // User clear input also clears the accumulator
  assign prbs_clear       = clr_q | in_rx_prbs_err_clr;
  assign out_prbs_err_clr = prbs_clear;

  assign out_set_rx_locktoref  = in_set_rx_locktoref | ctrl_reg[ctrl_set_locktoref];
  assign out_set_rx_locktodata = in_set_rx_locktodata | ctrl_reg[ctrl_set_locktodata];
  assign out_en_serial_lpbk    = in_en_serial_lpbk | ctrl_reg[ctrl_serial_lpbk];
  assign out_rx_analogreset    = in_rx_analogreset | ctrl_reg[ctrl_rx_analogreset];
  assign out_rx_digitalreset   = in_rx_digitalreset | ctrl_reg[ctrl_rx_digitalreset];
  assign out_tx_analogreset    = in_tx_analogreset | ctrl_reg[ctrl_tx_analogreset];
  assign out_tx_digitalreset   = in_tx_digitalreset | ctrl_reg[ctrl_tx_digitalreset];
  assign out_tx_cal_busy_mask  = cal_mask[mask_tx];
  assign out_rx_cal_busy_mask  = cal_mask[mask_rx];

  // Register commands are single-cycle pulses
  a_snap_pulse: assert property (@(posedge reconfig_clk) disable iff (rst)
    snap_q |=> !snap_q);
  a_clr_pulse: assert property (@(posedge reconfig_clk) disable iff (rst)
    clr_q |=> !clr_q);

endmodule

`default_nettype wire

/* src/rcfg_bus_ctrl.sv */
// ======================================================================
// Shared bus decode, transceiver or register routing, read wait state
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module rcfg_bus_ctrl #(
  parameter int CHANNELS = 2,
  localparam int sel_bits = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
) (
  input  wire                                              reconfig_clk,
  input  wire                                              rst,
  input  wire                                              reconfig_write,
  input  wire                                              reconfig_read,
  input  wire  [xcvr_rcfg_pkg::chan_addr_bits+sel_bits-1:0]  reconfig_address,
  input  wire  [xcvr_rcfg_pkg::data_width-1:0]               reconfig_writedata,
  output logic [xcvr_rcfg_pkg::data_width-1:0]               reconfig_readdata,
  output logic                                             reconfig_waitrequest,
  output logic [CHANNELS-1:0]                                avmm_write,
  output logic [CHANNELS-1:0]                                avmm_read,
  output logic [CHANNELS*xcvr_rcfg_pkg::chan_addr_bits-1:0]  avmm_address,
  output logic [CHANNELS*xcvr_rcfg_pkg::xcvr_data_width-1:0] avmm_writedata,
  input  wire  [CHANNELS*xcvr_rcfg_pkg::xcvr_data_width-1:0] avmm_readdata,
  input  wire  [CHANNELS-1:0]                                avmm_waitrequest,
  output logic [CHANNELS-1:0]                                csr_write,
  output logic [CHANNELS-1:0]                                csr_read,
  output logic [xcvr_rcfg_pkg::csr_offset_width-1:0]         csr_offset,
  output logic [xcvr_rcfg_pkg::xcvr_data_width-1:0]          csr_writedata,
  input  wire  [CHANNELS*xcvr_rcfg_pkg::xcvr_data_width-1:0] csr_readdata
);
  import xcvr_rcfg_pkg::*;

  logic [sel_bits-1:0]        chan_sel;
  logic                       is_csr;
  logic                       rd_pending;
  logic [xcvr_data_width-1:0] rd_byte;

  // Channel from the upper address bits, bank select from bit 9
  assign chan_sel = reconfig_address[chan_addr_bits +: sel_bits];
  assign is_csr   = reconfig_address[csr_sel_bit];

  for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_route
    logic hit;

    assign hit = (chan_sel == sel_bits'(ch));
    assign avmm_write[ch] = reconfig_write & ~is_csr & hit;
    assign avmm_read[ch]  = reconfig_read & ~is_csr & hit;
    assign avmm_address[ch*chan_addr_bits +: chan_addr_bits] =
      reconfig_address[chan_addr_bits-1:0];
    assign avmm_writedata[ch*xcvr_data_width +: xcvr_data_width] =
      reconfig_writedata[xcvr_data_width-1:0];
    assign csr_write[ch] = reconfig_write & is_csr & hit;
    // Capture only in the first cycle of a register read
    assign csr_read[ch]  = reconfig_read & is_csr & hit & ~rd_pending;
  end

  assign csr_offset    = reconfig_address[csr_offset_width-1:0];
  assign csr_writedata = reconfig_writedata[xcvr_data_width-1:0];

  // Register reads wait one cycle for the bank's registered byte
  always_ff @(posedge reconfig_clk) begin
    if (rst) begin
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= reconfig_read & is_csr & ~rd_pending;
    end
  end

  always_comb begin
    if (is_csr) begin
      rd_byte = csr_readdata[chan_sel*xcvr_data_width +: xcvr_data_width];
      reconfig_waitrequest = reconfig_read & ~rd_pending;
    end else begin
      rd_byte = avmm_readdata[chan_sel*xcvr_data_width +: xcvr_data_width];
      reconfig_waitrequest = (reconfig_read | reconfig_write) & avmm_waitrequest[chan_sel];
    end
  end

  assign reconfig_readdata = {{(data_width-xcvr_data_width){1'b0}}, rd_byte};

  // The single master never reads and writes at once
  a_no_rd_wr: assert property (@(posedge reconfig_clk) disable iff (rst)
    !(reconfig_read && reconfig_write));

  // Every access must address an existing channel
  a_chan_range: assert property (@(posedge reconfig_clk) disable iff (rst)
    (reconfig_read || reconfig_write) |-> (int'(chan_sel) < CHANNELS));

endmodule

`default_nettype wire

/* src/xcvr_rcfg_top.sv */
// ======================================================================
// Multi-channel reconfiguration wrapper with shared bus control,
// per-channel soft register banks and PRBS accumulators
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module xcvr_rcfg_top #(
  parameter int CHANNELS = 2,
  localparam int sel_bits = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
) (
  input  wire                                            reconfig_clk,
  input  wire                                            rst,
  input  wire                                            reconfig_write,
  input  wire                                            reconfig_read,
  input  wire [xcvr_rcfg_pkg::chan_addr_bits+sel_bits-1:0] reconfig_address,
  input  wire [xcvr_rcfg_pkg::data_width-1:0]              reconfig_writedata,
  output logic [xcvr_rcfg_pkg::data_width-1:0]             reconfig_readdata,
  output logic                                           reconfig_waitrequest,

  // Transceiver bus per channel
  output logic [CHANNELS-1:0]                              avmm_write,
  output logic [CHANNELS-1:0]                              avmm_read,
  output logic [CHANNELS*xcvr_rcfg_pkg::chan_addr_bits-1:0]  avmm_address,
  output logic [CHANNELS*xcvr_rcfg_pkg::xcvr_data_width-1:0] avmm_writedata,
  input  wire  [CHANNELS*xcvr_rcfg_pkg::xcvr_data_width-1:0] avmm_readdata,
  input  wire  [CHANNELS-1:0]                              avmm_waitrequest,

  input  wire  [CHANNELS-1:0] prbs_err_signal,
  input  wire  [CHANNELS-1:0] prbs_done_signal,

  input  wire  [CHANNELS-1:0] in_rx_is_lockedtoref,
  input  wire  [CHANNELS-1:0] in_rx_is_lockedtodata,
  input  wire  [CHANNELS-1:0] in_tx_cal_busy,
  input  wire  [CHANNELS-1:0] in_rx_cal_busy,

  input  wire  [CHANNELS-1:0] in_rx_prbs_err_clr,
  input  wire  [CHANNELS-1:0] in_set_rx_locktoref,
  input  wire  [CHANNELS-1:0] in_set_rx_locktodata,
  input  wire  [CHANNELS-1:0] in_en_serial_lpbk,
  input  wire  [CHANNELS-1:0] in_rx_analogreset,
  input  wire  [CHANNELS-1:0] in_rx_digitalreset,
  input  wire  [CHANNELS-1:0] in_tx_analogreset,
  input  wire  [CHANNELS-1:0] in_tx_digitalreset,

  output logic [CHANNELS-1:0] out_prbs_err_clr,
  output logic [CHANNELS-1:0] out_set_rx_locktoref,
  output logic [CHANNELS-1:0] out_set_rx_locktodata,
  output logic [CHANNELS-1:0] out_en_serial_lpbk,
  output logic [CHANNELS-1:0] out_rx_analogreset,
  output logic [CHANNELS-1:0] out_rx_digitalreset,
  output logic [CHANNELS-1:0] out_tx_analogreset,
  output logic [CHANNELS-1:0] out_tx_digitalreset,
  output logic [CHANNELS-1:0] out_tx_cal_busy_mask,
  output logic [CHANNELS-1:0] out_rx_cal_busy_mask
);
  import xcvr_rcfg_pkg::*;

  // Register bank side of the bus
  logic [CHANNELS-1:0]                 csr_write;
  logic [CHANNELS-1:0]                 csr_read;
  logic [csr_offset_width-1:0]         csr_offset;
  logic [xcvr_data_width-1:0]          csr_writedata;
  logic [CHANNELS*xcvr_data_width-1:0] csr_readdata;

  // PRBS commands and snapshots per channel
  logic [CHANNELS-1:0]                  prbs_count_en;
  logic [CHANNELS-1:0]                  prbs_snapshot;
  logic [CHANNELS-1:0]                  prbs_clear;
  logic [CHANNELS*prbs_count_width-1:0] err_snap;
  logic [CHANNELS*prbs_count_width-1:0] bit_snap;

  rcfg_bus_ctrl #(.CHANNELS(CHANNELS)) u_bus_ctrl (
    .reconfig_clk         (reconfig_clk),
    .rst                  (rst),
    .reconfig_write       (reconfig_write),
    .reconfig_read        (reconfig_read),
    .reconfig_address     (reconfig_address),
    .reconfig_writedata   (reconfig_writedata),
    .reconfig_readdata    (reconfig_readdata),
    .reconfig_waitrequest (reconfig_waitrequest),
    .avmm_write           (avmm_write),
    .avmm_read            (avmm_read),
    .avmm_address         (avmm_address),
    .avmm_writedata       (avmm_writedata),
    .avmm_readdata        (avmm_readdata),
    .avmm_waitrequest     (avmm_waitrequest),
    .csr_write            (csr_write),
    .csr_read             (csr_read),
    .csr_offset           (csr_offset),
    .csr_writedata        (csr_writedata),
    .csr_readdata         (csr_readdata)
  );

  for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_chan
    chan_soft_csr u_csr (
      .reconfig_clk          (reconfig_clk),
      .rst                   (rst),
      .csr_write             (csr_write[ch]),
      .csr_read              (csr_read[ch]),
      .csr_offset            (csr_offset),
      .csr_writedata         (csr_writedata),
      .csr_readdata          (csr_readdata[ch*xcvr_data_width +: xcvr_data_width]),
      .in_rx_is_lockedtoref  (in_rx_is_lockedtoref[ch]),
      .in_rx_is_lockedtodata (in_rx_is_lockedtodata[ch]),
      .in_tx_cal_busy        (in_tx_cal_busy[ch]),
      .in_rx_cal_busy        (in_rx_cal_busy[ch]),
      .in_rx_prbs_err_clr    (in_rx_prbs_err_clr[ch]),
      .in_set_rx_locktoref   (in_set_rx_locktoref[ch]),
      .in_set_rx_locktodata  (in_set_rx_locktodata[ch]),
      .in_en_serial_lpbk     (in_en_serial_lpbk[ch]),
      .in_rx_analogreset     (in_rx_analogreset[ch]),
      .in_rx_digitalreset    (in_rx_digitalreset[ch]),
      .in_tx_analogreset     (in_tx_analogreset[ch]),
      .in_tx_digitalreset    (in_tx_digitalreset[ch]),
      .prbs_done_signal      (prbs_done_signal[ch]),
      .err_snap              (err_snap[ch*prbs_count_width +: prbs_count_width]),
      .bit_snap              (bit_snap[ch*prbs_count_width +: prbs_count_width]),
      .prbs_count_en         (prbs_count_en[ch]),
      .prbs_snapshot         (prbs_snapshot[ch]),
      .prbs_clear            (prbs_clear[ch]),
      .out_prbs_err_clr      (out_prbs_err_clr[ch]),
      .out_set_rx_locktoref  (out_set_rx_locktoref[ch]),
      .out_set_rx_locktodata (out_set_rx_locktodata[ch]),
      .out_en_serial_lpbk    (out_en_serial_lpbk[ch]),
      .out_rx_analogreset    (out_rx_analogreset[ch]),
      .out_rx_digitalreset   (out_rx_digitalreset[ch]),
      .out_tx_analogreset    (out_tx_analogreset[ch]),
      .out_tx_digitalreset   (out_tx_digitalreset[ch]),
      .out_tx_cal_busy_mask  (out_tx_cal_busy_mask[ch]),
      .out_rx_cal_busy_mask  (out_rx_cal_busy_mask[ch])
    );

    prbs_accum u_accum (
      .reconfig_clk     (reconfig_clk),
      .rst              (rst),
      .prbs_count_en    (prbs_count_en[ch]),
      .prbs_snapshot    (prbs_snapshot[ch]),
      .prbs_clear       (prbs_clear[ch]),
      .prbs_err_signal  (prbs_err_signal[ch]),
      .prbs_done_signal (prbs_done_signal[ch]),
      .err_snap         (err_snap[ch*prbs_count_width +: prbs_count_width]),
      .bit_snap         (bit_snap[ch*prbs_count_width +: prbs_count_width])
    );
  end

endmodule

`default_nettype wire

/* test/rcfg_checker.sv */
// ======================================================================
// Response checker: completed bus reads, static output words, counts
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module rcfg_checker (
  input wire        reconfig_clk,
  input wire        rst,
  input wire        reconfig_read,
  input wire        reconfig_waitrequest,
  input wire [31:0] reconfig_readdata,
  input wire [31:0] obs
);

  int          pass_cnt = 0;
  int          fail_cnt = 0;
  bit          armed = 1'b0;
  string       read_name;
  logic [31:0] read_exp;

  task automatic show_result(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act === exp) begin
      pass_cnt++;
      $display("PASS %s", name);
    end else begin
      fail_cnt++;
      $display("FAIL %s expected 0x%08h actual 0x%08h", name, exp, act);
    end
  endtask

  // Armed by the testbench before each read starts
  task automatic expect_read(input string name, input logic [31:0] exp);
    read_name = name;
    read_exp  = exp;
    armed     = 1'b1;
  endtask

  task automatic check_static(input string name, input logic [31:0] exp);
    show_result(name, exp, obs);
  endtask

  task automatic report_error(input string msg);
    fail_cnt++;
    $display("ERROR %s", msg);
  endtask

  task automatic summary();
    $display("Checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
  endtask

  // A read completes on the edge where waitrequest is low
  always @(posedge reconfig_clk) begin
    if (!rst && armed && reconfig_read && !reconfig_waitrequest) begin
      armed = 1'b0;
      show_result(read_name, read_exp, reconfig_readdata);
    end
  end

endmodule

`default_nettype wire

/* test/tb_xcvr_rcfg.sv */
// ======================================================================
// Testbench: clock, reset, stimulus table, bus tasks, transceiver model
// and PRBS pattern driver
// ======================================================================
`timescale 1ns/1ns
`default_nettype none

module tb_xcvr_rcfg;

  localparam int op_wr = 0, op_rd = 1, op_tally = 2, op_burst = 3, op_static = 4, op_uclr = 5;
  localparam int max_wait = 50;

  logic reconfig_clk = 1'b0;
  logic rst = 1'b1;
  logic reconfig_write, reconfig_read;
  logic [10:0] reconfig_address;
  logic [31:0] reconfig_writedata, reconfig_readdata;
  logic reconfig_waitrequest;
  logic [1:0] avmm_write, avmm_read, avmm_waitrequest;
  logic [19:0] avmm_address;
  logic [15:0] avmm_writedata, avmm_readdata;
  logic [1:0] prbs_err_signal, prbs_done_signal, in_rx_prbs_err_clr;
  logic [1:0] in_rx_is_lockedtoref, in_rx_is_lockedtodata, in_tx_cal_busy, in_rx_cal_busy;
  logic [1:0] in_set_rx_locktoref, in_set_rx_locktodata, in_en_serial_lpbk;
  logic [1:0] in_rx_analogreset, in_rx_digitalreset, in_tx_analogreset, in_tx_digitalreset;
  logic [1:0] out_prbs_err_clr, out_set_rx_locktoref, out_set_rx_locktodata;
  logic [1:0] out_en_serial_lpbk, out_rx_analogreset, out_rx_digitalreset;
  logic [1:0] out_tx_analogreset, out_tx_digitalreset, out_tx_cal_busy_mask, out_rx_cal_busy_mask;

  // Transceiver model state and observation words
  logic [1:0]  wait_cnt [2];
  logic [7:0]  last_wr [2];
  logic [7:0]  wr_cnt [2];
  logic [7:0]  clr_cnt [2];
  logic [9:0]  ovec [2];
  logic [1:0]  obs_sel = 2'd0;
  logic [31:0] obs;
  logic [31:0] lcg_state = 32'd5018;
  longint      err_tally [2];
  longint      bit_tally [2];
  bit          prbs_en [2];

  string       tname [$];
  int          top [$];
  logic [10:0] taddr [$];
  logic [31:0] tdata [$];
  logic [31:0] texp [$];

  xcvr_rcfg_top #(.CHANNELS(2)) dut (.*);

  rcfg_checker chk (
    .reconfig_clk(reconfig_clk), .rst(rst), .reconfig_read(reconfig_read),
    .reconfig_waitrequest(reconfig_waitrequest), .reconfig_readdata(reconfig_readdata),
    .obs(obs)
  );

  always #20 reconfig_clk = ~reconfig_clk;

  function automatic logic [31:0] lcg_draw();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // Order follows the control register with masks on top and clear at the bottom
  function automatic logic [9:0] ctrl_vec(input logic rxm, input logic txm,
                                          input logic [6:0] ctrl, input logic clr);
    return {rxm, txm, ctrl, clr};
  endfunction

  for (genvar ch = 0; ch < 2; ch++) begin : g_model
    assign avmm_waitrequest[ch] = (avmm_read[ch] | avmm_write[ch]) & (wait_cnt[ch] != 2'd0);
    // Only a channel that sees its own read strobe answers
    assign avmm_readdata[ch*8 +: 8] =
      avmm_read[ch] ? (avmm_address[ch*10 +: 8] ^ 8'(ch)) : 8'h00;
    assign ovec[ch] = {out_rx_cal_busy_mask[ch], out_tx_cal_busy_mask[ch],
      out_tx_digitalreset[ch], out_tx_analogreset[ch], out_rx_digitalreset[ch],
      out_rx_analogreset[ch], out_en_serial_lpbk[ch], out_set_rx_locktodata[ch],
      out_set_rx_locktoref[ch], out_prbs_err_clr[ch]};
  end

  always_comb begin
    case (obs_sel)
      2'd0: obs = {12'h0, ovec[1], ovec[0]};
      2'd1: obs = {wr_cnt[0], wr_cnt[1], last_wr[0], last_wr[1]};
      default: obs = {16'h0, clr_cnt[1], clr_cnt[0]};
    endcase
  end

  // Stall each access for a drawn 0 to 3 cycles and log writes and clear pulses
  always @(posedge reconfig_clk) begin
    for (int ch = 0; ch < 2; ch++) begin
      if (rst) begin
        wait_cnt[ch] <= 2'd0;
        last_wr[ch]  <= 8'h0;
        wr_cnt[ch]   <= 8'h0;
        clr_cnt[ch]  <= 8'h0;
      end else begin
        if (out_prbs_err_clr[ch]) clr_cnt[ch] <= clr_cnt[ch] + 8'd1;
        if (avmm_read[ch] || avmm_write[ch]) begin
          if (wait_cnt[ch] != 2'd0) begin
            wait_cnt[ch] <= wait_cnt[ch] - 2'd1;
          end else begin
            wait_cnt[ch] <= lcg_draw() % 4;
            if (avmm_write[ch]) begin
              last_wr[ch] <= avmm_writedata[ch*8 +: 8];
              wr_cnt[ch]  <= wr_cnt[ch] + 8'd1;
            end
          end
        end
      end
    end
  end

  task automatic add(input string n, input int op, input logic [10:0] a,
                     input logic [31:0] d, input logic [31:0] e);
    tname.push_back(n);
    top.push_back(op);
    taddr.push_back(a);
    tdata.push_back(d);
    texp.push_back(e);
  endtask

  task automatic bus_access(input bit wr, input logic [10:0] a, input logic [31:0] d);
    int n;
    n = 0;
    @(negedge reconfig_clk);
    reconfig_write     = wr;
    reconfig_read      = !wr;
    reconfig_address   = a;
    reconfig_writedata = d;
    @(posedge reconfig_clk);
    while (reconfig_waitrequest && n < max_wait) begin
      n++;
      @(posedge reconfig_clk);
    end
    if (n >= max_wait) chk.report_error($sformatf("bus access to 0x%03h timed out", a));
    @(negedge reconfig_clk);
    reconfig_write = 1'b0;
    reconfig_read  = 1'b0;
  endtask

  task automatic prbs_burst(input int ch, input int cycles);
    logic e;
    for (int i = 0; i < cycles; i++) begin
      @(negedge reconfig_clk);
      e = lcg_draw() % 2;
      prbs_done_signal[ch] = 1'b1;
      prbs_err_signal[ch]  = e;
      if (prbs_en[ch]) begin
        bit_tally[ch]++;
        if (e) err_tally[ch]++;
      end
    end
    @(negedge reconfig_clk);
    prbs_done_signal[ch] = 1'b0;
    prbs_err_signal[ch]  = 1'b0;
  endtask

  initial begin
    int ch;
    logic [8:0] off;
    longint tally;
    reconfig_write        = 1'b0;
    reconfig_read         = 1'b0;
    reconfig_address      = '0;
    reconfig_writedata    = '0;
    prbs_err_signal       = '0;
    prbs_done_signal      = '0;
    in_rx_prbs_err_clr    = '0;
    in_rx_is_lockedtoref  = 2'b11;
    in_rx_is_lockedtodata = 2'b01;
    in_tx_cal_busy        = 2'b10;
    in_rx_cal_busy        = 2'b01;
    in_set_rx_locktoref   = 2'b10;
    in_set_rx_locktodata  = '0;
    in_en_serial_lpbk     = '0;
    in_rx_analogreset     = '0;
    in_rx_digitalreset    = '0;
    in_tx_analogreset     = '0;
    in_tx_digitalreset    = '0;
    for (int c = 0; c < 2; c++) begin
      err_tally[c] = 0;
      bit_tally[c] = 0;
      prbs_en[c]   = 0;
    end

    // Channel address is {channel, bank select, 9-bit offset}
    add("rd_ch0_xcvr", op_rd, 11'h045, 0, 32'h45);
    add("rd_ch1_xcvr", op_rd, 11'h4b3, 0, 32'hb2);
    add("wr_ch1_xcvr", op_wr, 11'h4a7, 32'h123456c3, 0);
    add("wr_routing", op_static, 11'd1, 0, 32'h000100c3);
    add("reset_outputs", op_static, 11'd0, 0,
        {12'h0, ctrl_vec(1, 1, 7'h01, 0), ctrl_vec(1, 1, 7'h00, 0)});
    // Status is {prbs done, rx cal, tx cal, locked data, locked ref}
    add("status_ch0", op_rd, 11'h201, 0, 32'h0b);
    add("status_ch1", op_rd, 11'h601, 0, 32'h05);
    add("mask_default", op_rd, 11'h203, 0, 32'h03);
    add("wr_ctrl_ch0", op_wr, 11'h202, 32'h55, 0);
    add("wr_mask_ch0", op_wr, 11'h203, 32'h02, 0);
    add("override_outputs", op_static, 11'd0, 0,
        {12'h0, ctrl_vec(1, 1, 7'h01, 0), ctrl_vec(1, 0, 7'h55, 0)});
    add("ctrl_readback", op_rd, 11'h202, 0, 32'h55);
    add("mask_readback", op_rd, 11'h203, 0, 32'h02);
    add("prbs_enable", op_wr, 11'h204, 32'h01, 0);
    add("prbs_burst", op_burst, 11'd0, 300, 0);
    add("prbs_stop_snap", op_wr, 11'h204, 32'h02, 0);
    for (int b = 0; b < 7; b++) add($sformatf("err_byte%0d", b), op_tally, 11'h208 + b, 0, 0);
    for (int b = 0; b < 7; b++) add($sformatf("bit_byte%0d", b), op_tally, 11'h210 + b, 0, 0);
    add("wr_ctrl_ch1", op_wr, 11'h602, 32'h7f, 0);
    add("wr_mask_ch1", op_wr, 11'h603, 32'h00, 0);
    // A PRBS clear on channel 1 must leave channel 0's counts alone
    add("wr_prbs_clr_ch1", op_wr, 11'h604, 32'h04, 0);
    add("isolation_outputs", op_static, 11'd0, 0,
        {12'h0, ctrl_vec(0, 0, 7'h7f, 0), ctrl_vec(1, 0, 7'h55, 0)});
    add("isolation_err0", op_tally, 11'h208, 0, 0);
    add("isolation_bit1", op_tally, 11'h211, 0, 0);
    add("prbs_clear_cmd", op_wr, 11'h204, 32'h04, 0);
    add("clear_pulse_ch0", op_static, 11'd2, 0, 32'h0101);
    add("user_clear_ch1", op_uclr, 11'd1, 0, 0);
    add("clear_pulse_ch1", op_static, 11'd2, 0, 32'h0201);
    add("snap_after_clear", op_wr, 11'h204, 32'h02, 0);
    add("cleared_err0", op_tally, 11'h208, 0, 0);
    add("cleared_bit0", op_tally, 11'h210, 0, 0);

    repeat (8) @(posedge reconfig_clk);
    @(negedge reconfig_clk);
    rst = 1'b0;

    for (int i = 0; i < tname.size(); i++) begin
      ch  = taddr[i][10];
      off = taddr[i][8:0];
      case (top[i])
        op_wr: begin
          // Track enable and clear so the expected tally follows the commands
          if (taddr[i][9] && off == 9'h004) begin
            prbs_en[ch] = tdata[i][0];
            if (tdata[i][2]) begin
              err_tally[ch] = 0;
              bit_tally[ch] = 0;
            end
          end
          bus_access(1'b1, taddr[i], tdata[i]);
        end
        op_rd, op_tally: begin
          if (top[i] == op_tally) begin
            tally = (off < 9'h010) ? err_tally[ch] : bit_tally[ch];
            texp[i] = 32'((tally >> (8 * off[2:0])) & 64'hff);
          end
          chk.expect_read(tname[i], texp[i]);
          bus_access(1'b0, taddr[i], 0);
          if (chk.armed) chk.report_error({tname[i], " finished without a checked read"});
        end
        op_burst: prbs_burst(taddr[i][0], tdata[i]);
        op_static: begin
          obs_sel = taddr[i][1:0];
          repeat (2) @(negedge reconfig_clk);
          chk.check_static(tname[i], texp[i]);
        end
        default: begin
          @(negedge reconfig_clk);
          in_rx_prbs_err_clr[taddr[i][0]] = 1'b1;
          @(negedge reconfig_clk);
          in_rx_prbs_err_clr[taddr[i][0]] = 1'b0;
          err_tally[taddr[i][0]] = 0;
          bit_tally[taddr[i][0]] = 0;
        end
      endcase
    end

    chk.summary();
    if (chk.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* xcvr_rcfg_top.f */
src/xcvr_rcfg_pkg.sv
src/prbs_accum.sv
src/chan_soft_csr.sv
src/rcfg_bus_ctrl.sv
src/xcvr_rcfg_top.sv
test/rcfg_checker.sv
test/tb_xcvr_rcfg.sv

/* Makefile */
# Verilator build and run for the reconfiguration wrapper

VERILATOR ?= verilator
TB_TOP    ?= tb_xcvr_rcfg
RTL_TOP   ?= xcvr_rcfg_top
FILELIST  ?= xcvr_rcfg_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) \
		src/xcvr_rcfg_pkg.sv src/prbs_accum.sv src/chan_soft_csr.sv \
		src/rcfg_bus_ctrl.sv src/xcvr_rcfg_top.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)
